//--- source/periph_pkg.sv
//////////////////////////////////////////////////////////////////////
// Peripheral subsystem package
// Bus request and response structs, bus operation and device select
// enums, the address map, the register offsets of the devices and
// the byte-lane merge used by every writable register
//////////////////////////////////////////////////////////////////////

package periph_pkg;

  localparam int unsigned BusAddrWidth = 32;
  localparam int unsigned BusDataWidth = 32;
  localparam int unsigned BusBeWidth   = BusDataWidth / 8;

  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } bus_op_e;

  typedef struct packed {
    bus_op_e                 op;
    logic [BusAddrWidth-1:0] addr;
    logic [BusBeWidth-1:0]   be;
    logic [BusDataWidth-1:0] wdata;
  } bus_req_t; // 69 bits

  typedef struct packed {
    logic [BusDataWidth-1:0] rdata;
    logic                    err;
  } bus_rsp_t; // 33 bits

  typedef enum logic [1:0] {
    DevSram  = 2'd0,
    DevGpio  = 2'd1,
    DevTimer = 2'd2,
    DevNone  = 2'd3
  } dev_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////

  localparam logic [BusAddrWidth-1:0] SramBase      = 32'h0010_0000;
  localparam logic [BusAddrWidth-1:0] GpioBase      = 32'h8000_0000;
  localparam logic [BusAddrWidth-1:0] TimerBase     = 32'h8004_0000;
  localparam logic [BusAddrWidth-1:0] DevRegionMask = 32'hFFFF_0000; // 64 KiB per device

  localparam int unsigned RegAddrWidth = 8;

  // GPIO registers
  localparam logic [RegAddrWidth-1:0] GpioOutOffset = 8'h00;
  localparam logic [RegAddrWidth-1:0] GpioInOffset  = 8'h04;

  // Timer registers
  localparam logic [RegAddrWidth-1:0] TimerMtimeLoOffset = 8'h00;
  localparam logic [RegAddrWidth-1:0] TimerMtimeHiOffset = 8'h04;
  localparam logic [RegAddrWidth-1:0] TimerCmpLoOffset   = 8'h08;
  localparam logic [RegAddrWidth-1:0] TimerCmpHiOffset   = 8'h0C;
  localparam logic [RegAddrWidth-1:0] TimerCtrlOffset    = 8'h10;

  // Replace only the enabled byte lanes of the old word
  function automatic logic [BusDataWidth-1:0] be_merge(
    input logic [BusDataWidth-1:0] old_data,
    input logic [BusDataWidth-1:0] new_data,
    input logic [BusBeWidth-1:0]   be
  );
    logic [BusDataWidth-1:0] merged;
    merged = old_data;
    for (int i = 0; i < BusBeWidth; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_data[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- source/bus_decoder.sv
//////////////////////////////////////////////////////////////////////
// Bus decoder
// Decodes the host address into a device select, strobes the chosen
// device on acceptance and returns its read data as the response.
// Unmapped addresses answer with an error.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bus_decoder import periph_pkg::*; (
  input  logic                    clk_sys_i,
  input  logic                    rst_sys_ni,

  // Host side
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  bus_req_t                req_i,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output bus_rsp_t                rsp_o,

  // Device side
  output bus_req_t                dev_req_o,
  output logic                    sram_req_o,
  output logic                    gpio_req_o,
  output logic                    timer_req_o,
  input  logic [BusDataWidth-1:0] sram_rdata_i,
  input  logic [BusDataWidth-1:0] gpio_rdata_i,
  input  logic [BusDataWidth-1:0] timer_rdata_i
);

  logic                    rsp_pending_q;
  logic                    accept;
  logic [BusAddrWidth-1:0] region;
  dev_sel_e                sel_d;
  dev_sel_e                sel_q;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Free slot, or the slot empties this cycle
  assign req_ready_o = ~rsp_pending_q | rsp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  assign region = req_i.addr & DevRegionMask;

  always_comb begin
    case (region)
      SramBase:  sel_d = DevSram;
      GpioBase:  sel_d = DevGpio;
      TimerBase: sel_d = DevTimer;
      default:   sel_d = DevNone;
    endcase
  end

  // Shared request, address cut down to the offset inside the window
  assign dev_req_o = '{
    op:    req_i.op,
    addr:  req_i.addr & ~DevRegionMask,
    be:    req_i.be,
    wdata: req_i.wdata
  };

  assign sram_req_o  = accept & (sel_d == DevSram);
  assign gpio_req_o  = accept & (sel_d == DevGpio);
  assign timer_req_o = accept & (sel_d == DevTimer);

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_pending_q <= 1'b0;
      sel_q         <= DevNone;
    end else if (accept) begin
      rsp_pending_q <= 1'b1; // Back-to-back, old response taken this cycle
      sel_q         <= sel_d;
    end else if (rsp_ready_i) begin
      rsp_pending_q <= 1'b0;
    end
  end

  assign rsp_valid_o = rsp_pending_q;

  // Device read data holds until its next strobe, so the mux stays stable
  always_comb begin
    rsp_o = '0;
    case (sel_q)
      DevSram:  rsp_o.rdata = sram_rdata_i;
      DevGpio:  rsp_o.rdata = gpio_rdata_i;
      DevTimer: rsp_o.rdata = timer_rdata_i;
      default:  rsp_o.err   = 1'b1; // Unmapped
    endcase
  end

endmodule

//--- source/sram_device.sv
//////////////////////////////////////////////////////////////////////
// SRAM device
// Single-port word memory with byte-enable writes and one cycle of
// read latency
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_device import periph_pkg::*; #(
  parameter int unsigned SramDepth = 1024
) (
  input  logic                    clk_sys_i,
  input  logic                    rst_sys_ni,
  input  logic                    req_i,
  input  bus_req_t                dev_req_i,
  output logic [BusDataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = $clog2(SramDepth);

  logic [BusDataWidth-1:0] mem [SramDepth];
  logic [IdxWidth-1:0]     word_idx;
  logic                    wr_en;

  // Byte address to word index
  assign word_idx = dev_req_i.addr[IdxWidth+1:2];
  assign wr_en    = req_i & (dev_req_i.op == OpWrite);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i) begin
    if (wr_en) begin
      mem[word_idx] <= be_merge(mem[word_idx], dev_req_i.wdata, dev_req_i.be);
    end
  end

  // Read port
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      if (dev_req_i.op == OpRead) begin
        rdata_o <= mem[word_idx];
      end else begin
        rdata_o <= '0; // Writes answer with zero
      end
    end
  end

endmodule

//--- source/gpio_device.sv
//////////////////////////////////////////////////////////////////////
// GPIO device
// Output register driving gp_o and a two-flop synchroniser on gp_i,
// both readable over the bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module gpio_device import periph_pkg::*; #(
  parameter int unsigned GpiWidth = 13,
  parameter int unsigned GpoWidth = 24
) (
  input  logic                    clk_sys_i,
  input  logic                    rst_sys_ni,
  input  logic                    req_i,
  input  bus_req_t                dev_req_i,
  output logic [BusDataWidth-1:0] rdata_o,
  input  logic [GpiWidth-1:0]     gp_i,
  output logic [GpoWidth-1:0]     gp_o
);

  logic [GpoWidth-1:0]     gpo_q;
  logic [GpiWidth-1:0]     gpi_meta_q;
  logic [GpiWidth-1:0]     gpi_sync_q;
  logic [RegAddrWidth-1:0] offset;
  logic [BusDataWidth-1:0] wide_gpo;
  logic [BusDataWidth-1:0] rdata_d;

  assign offset   = dev_req_i.addr[RegAddrWidth-1:0];
  assign wide_gpo = BusDataWidth'(gpo_q);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q <= '0;
    end else if (req_i && dev_req_i.op == OpWrite && offset == GpioOutOffset) begin
      gpo_q <= GpoWidth'(be_merge(wide_gpo, dev_req_i.wdata, dev_req_i.be));
    end
  end

  assign gp_o = gpo_q;

  // Input synchroniser, two cycles of lag
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  always_comb begin
    case (offset)
      GpioOutOffset: rdata_d = wide_gpo;
      GpioInOffset:  rdata_d = BusDataWidth'(gpi_sync_q);
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= (dev_req_i.op == OpRead) ? rdata_d : '0;
    end
  end

endmodule

//--- source/timer_device.sv
//////////////////////////////////////////////////////////////////////
// Machine timer
// 64-bit mtime counter and mtimecmp compare register, each written a
// half at a time, with an enable bit and a registered interrupt
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module timer_device import periph_pkg::*; (
  input  logic                    clk_sys_i,
  input  logic                    rst_sys_ni,
  input  logic                    req_i,
  input  bus_req_t                dev_req_i,
  output logic [BusDataWidth-1:0] rdata_o,
  output logic                    timer_irq_o
);

  logic [63:0]             mtime_q;
  logic [63:0]             mtimecmp_q;
  logic                    enable_q;
  logic [RegAddrWidth-1:0] offset;
  logic                    wr_en;
  logic [BusDataWidth-1:0] rdata_d;

  assign offset = dev_req_i.addr[RegAddrWidth-1:0];
  assign wr_en  = req_i & (dev_req_i.op == OpWrite);

  //////////////////////////////////////////////////////////////////////
  // Counter
  //////////////////////////////////////////////////////////////////////

  // A bus write to either half wins over the increment
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q <= '0;
    end else if (wr_en && offset == TimerMtimeLoOffset) begin
      mtime_q[31:0] <= be_merge(mtime_q[31:0], dev_req_i.wdata, dev_req_i.be);
    end else if (wr_en && offset == TimerMtimeHiOffset) begin
      mtime_q[63:32] <= be_merge(mtime_q[63:32], dev_req_i.wdata, dev_req_i.be);
    end else if (enable_q) begin
      mtime_q <= mtime_q + 64'd1;
    end
  end

  // Compare and control
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtimecmp_q <= '1; // Far future, no interrupt
      enable_q   <= 1'b0;
    end else if (wr_en) begin
      case (offset)
        TimerCmpLoOffset: begin
          mtimecmp_q[31:0] <= be_merge(mtimecmp_q[31:0], dev_req_i.wdata, dev_req_i.be);
        end
        TimerCmpHiOffset: begin
          mtimecmp_q[63:32] <= be_merge(mtimecmp_q[63:32], dev_req_i.wdata, dev_req_i.be);
        end
        TimerCtrlOffset: begin
          if (dev_req_i.be[0]) begin
            enable_q <= dev_req_i.wdata[0];
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= enable_q & (mtime_q >= mtimecmp_q);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (offset)
      TimerMtimeLoOffset: rdata_d = mtime_q[31:0];
      TimerMtimeHiOffset: rdata_d = mtime_q[63:32];
      TimerCmpLoOffset:   rdata_d = mtimecmp_q[31:0];
      TimerCmpHiOffset:   rdata_d = mtimecmp_q[63:32];
      TimerCtrlOffset:    rdata_d = {{(BusDataWidth-1){1'b0}}, enable_q};
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= (dev_req_i.op == OpRead) ? rdata_d : '0;
    end
  end

endmodule

//--- source/periph_top.sv
//////////////////////////////////////////////////////////////////////
// Peripheral subsystem top
// One valid/ready bus port decoded onto SRAM, GPIO and machine timer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module periph_top import periph_pkg::*; #(
  parameter int unsigned GpiWidth  = 13,
  parameter int unsigned GpoWidth  = 24,
  parameter int unsigned SramDepth = 1024
) (
  input  logic                clk_sys_i,
  input  logic                rst_sys_ni,

  // Host port
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  bus_req_t            req_i,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output bus_rsp_t            rsp_o,

  input  logic [GpiWidth-1:0] gp_i,
  output logic [GpoWidth-1:0] gp_o,
  output logic                timer_irq_o
);

  bus_req_t                dev_req;
  logic                    sram_req;
  logic                    gpio_req;
  logic                    timer_req;
  logic [BusDataWidth-1:0] sram_rdata;
  logic [BusDataWidth-1:0] gpio_rdata;
  logic [BusDataWidth-1:0] timer_rdata;

  bus_decoder u_bus_decoder (
    .clk_sys_i    (clk_sys_i),
    .rst_sys_ni   (rst_sys_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_o        (rsp_o),
    .dev_req_o    (dev_req),
    .sram_req_o   (sram_req),
    .gpio_req_o   (gpio_req),
    .timer_req_o  (timer_req),
    .sram_rdata_i (sram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .timer_rdata_i(timer_rdata)
  );

  sram_device #(
    .SramDepth ( SramDepth )
  ) u_sram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (sram_req),
    .dev_req_i (dev_req),
    .rdata_o   (sram_rdata)
  );

  gpio_device #(
    .GpiWidth ( GpiWidth ),
    .GpoWidth ( GpoWidth )
  ) u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (gpio_req),
    .dev_req_i (dev_req),
    .rdata_o   (gpio_rdata),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  timer_device u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (timer_req),
    .dev_req_i  (dev_req),
    .rdata_o    (timer_rdata),
    .timer_irq_o(timer_irq_o) // No core here, goes straight out
  );

endmodule

//--- testbench/periph_asserts.sv
//////////////////////////////////////////////////////////////////////
// Bus decoder assertions
// Reset state and valid/ready rules of the host response channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module periph_asserts import periph_pkg::*; (
  input logic     clk_sys_i,
  input logic     rst_sys_ni,
  input logic     req_valid_i,
  input logic     req_ready_i,
  input logic     rsp_valid_i,
  input logic     rsp_ready_i,
  input bus_rsp_t rsp_i
);

  int error_count = 0; // Read by the testbench at the end

  a_idle_after_reset: assert property (@(posedge clk_sys_i)
    $rose(rst_sys_ni) |-> !rsp_valid_i)
    else begin $error("Response valid right after reset"); error_count++; end

  a_rsp_stable: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rsp_valid_i && !rsp_ready_i |=> $stable(rsp_i))
    else begin $error("Response payload moved while stalled"); error_count++; end

  a_no_accept_on_stall: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    rsp_valid_i && !rsp_ready_i |-> !req_ready_i)
    else begin $error("Request ready while response stalled"); error_count++; end

  a_rsp_follows_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_valid_i && req_ready_i |=> rsp_valid_i)
    else begin $error("Accepted request gave no response"); error_count++; end

endmodule

bind bus_decoder periph_asserts u_periph_asserts (
  .clk_sys_i  (clk_sys_i),
  .rst_sys_ni (rst_sys_ni),
  .req_valid_i(req_valid_i),
  .req_ready_i(req_ready_o),
  .rsp_valid_i(rsp_valid_o),
  .rsp_ready_i(rsp_ready_i),
  .rsp_i      (rsp_o)
);

//--- testbench/tb_periph_top.sv
//////////////////////////////////////////////////////////////////////
// Peripheral subsystem testbench
// Replays the golden command file against the subsystem top level:
// bus reads and writes with random response stalls, GPIO pin drive
// and checks, timer interrupt levels and a running mtime count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_periph_top
  import periph_pkg::*;
();

  localparam int unsigned ClkPeriod       = 40;
  localparam int unsigned GpiWidth        = 13;
  localparam int unsigned GpoWidth        = 24;
  localparam int unsigned SramDepth       = 1024;
  localparam int unsigned WaitLimit       = 64;   // Cycles before a wait gives up
  localparam int unsigned GpiSettleCycles = 4;
  localparam logic [31:0] Seed            = 32'ha756e346;
  localparam string       GoldenFile      = "testbench/periph_golden.txt";

  logic                clk_sys = 1'b0;
  logic                rst_sys_n;
  logic                req_valid;
  logic                req_ready;
  bus_req_t            req;
  logic                rsp_valid;
  logic                rsp_ready;
  bus_rsp_t            rsp;
  logic [GpiWidth-1:0] gp_in;
  logic [GpoWidth-1:0] gp_out;
  logic                timer_irq;

  always #(ClkPeriod / 2) clk_sys = ~clk_sys;

  periph_top #(
    .GpiWidth ( GpiWidth  ),
    .GpoWidth ( GpoWidth  ),
    .SramDepth( SramDepth )
  ) dut (
    .clk_sys_i  (clk_sys),
    .rst_sys_ni (rst_sys_n),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_i      (req),
    .rsp_valid_o(rsp_valid),
    .rsp_ready_i(rsp_ready),
    .rsp_o      (rsp),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .timer_irq_o(timer_irq)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_rsp(input bus_rsp_t actual, input bus_rsp_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf(
        "Error: time %0t rsp_o actual rdata=%h err=%b expected rdata=%h err=%b",
        $time, actual.rdata, actual.err, expected.rdata, expected.err));
    end
  endtask

  task automatic check_gpo(input logic [GpoWidth-1:0] actual,
                           input logic [GpoWidth-1:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: time %0t gp_o actual %h expected %h",
                                  $time, actual, expected));
    end
  endtask

  task automatic check_irq(input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Error: time %0t timer_irq_o actual %b expected %b",
                                  $time, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and pin drivers, all entered and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic bus_xfer(input bus_req_t req_in, output bus_rsp_t got);
    int unsigned stall;
    int unsigned waited;
    req_valid = 1'b1;
    req       = req_in;
    waited    = 0;
    #(ClkPeriod / 4); // Mid low phase, ready has settled
    while (!req_ready) begin
      waited++;
      if (waited > WaitLimit) begin
        stop_with_failure("The request was never accepted by the DUT");
      end
      @(negedge clk_sys);
      #(ClkPeriod / 4);
    end
    @(negedge clk_sys); // Accepted at the rising edge just passed
    req_valid = 1'b0;
    req       = '0;
    stall     = $urandom % 4;
    if (stall > 0) begin
      rsp_ready = 1'b0;
      repeat (stall) @(negedge clk_sys);
    end
    rsp_ready = 1'b1;
    waited    = 0;
    while (!rsp_valid) begin
      waited++;
      if (waited > WaitLimit) begin
        stop_with_failure("No response came back for an accepted request");
      end
      @(negedge clk_sys);
    end
    got = rsp;
    @(negedge clk_sys); // Response taken
  endtask

  task automatic drive_gpi(input logic [GpiWidth-1:0] value);
    gp_in = value;
    repeat (GpiSettleCycles) @(negedge clk_sys); // Let the synchroniser catch up
  endtask

  task automatic wait_irq(input logic level);
    int unsigned waited;
    waited = 0;
    while (timer_irq !== level && waited < WaitLimit) begin
      waited++;
      @(negedge clk_sys);
    end
    check_irq(timer_irq, level); // Still wrong here means the wait timed out
  endtask

  // Two back-to-back mtime_lo reads with the timer running
  task automatic check_mtime_count();
    bus_req_t rd;
    bus_rsp_t first;
    bus_rsp_t second;
    rd = '{op: OpRead, addr: TimerBase | 32'(TimerMtimeLoOffset), be: '1, wdata: '0};
    bus_xfer(rd, first);
    bus_xfer(rd, second);
    if (first.err || second.err) begin
      stop_with_failure("A read of mtime_lo returned an error response");
    end
    if (second.rdata <= first.rdata) begin
      stop_with_failure($sformatf("mtime_lo did not advance between reads, %h then %h",
                                  first.rdata, second.rdata));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int          fd;
    int          n;
    int          line_no;
    string       line;
    byte         cmd;
    logic [31:0] field [5];
    bus_req_t    cur_req;
    bus_rsp_t    exp_rsp;
    bus_rsp_t    got_rsp;

    rst_sys_n  = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    rsp_ready  = 1'b1;
    gp_in      = '0;
    line_no    = 0;
    void'($urandom(Seed));

    repeat (2) @(negedge clk_sys);
    rst_sys_n = 1'b1;

    fd = $fopen(GoldenFile, "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the golden stimulus file");
    end

    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      line_no++;
      if (n == 0 || line.len() == 0) continue;
      if (line.getc(0) == "#" || line.getc(0) == "\n" || line.getc(0) == "\r") continue;
      n = $sscanf(line, "%c %h %h %h %h %h", cmd, field[0], field[1], field[2],
                  field[3], field[4]);
      case (cmd)
        "R", "W": begin
          if (n != 6) begin
            stop_with_failure($sformatf("Bus command on line %0d is incomplete", line_no));
          end
          cur_req = '{op:    (cmd == "W") ? OpWrite : OpRead,
                      addr:  field[0],
                      be:    field[1][BusBeWidth-1:0],
                      wdata: field[2]};
          exp_rsp = '{rdata: field[3], err: field[4][0]};
          bus_xfer(cur_req, got_rsp);
          check_rsp(got_rsp, exp_rsp);
        end
        "G":     drive_gpi(field[0][GpiWidth-1:0]);
        "O":     check_gpo(gp_out, field[0][GpoWidth-1:0]);
        "I":     wait_irq(field[0][0]);
        "M":     check_mtime_count();
        default: stop_with_failure($sformatf("Unknown command on line %0d", line_no));
      endcase
    end
    $fclose(fd);

    if (dut.u_bus_decoder.u_periph_asserts.error_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      stop_with_failure("Bus handshake assertions failed during the run");
    end
  end

endmodule

//--- testbench/periph_golden.txt
# R/W addr be wdata exp_rdata exp_err | G gp_i | O gp_o | I irq level | M mtime check
# All values hex; R/W run one bus transfer, the others act on pins
I 0
W 00100000 f 11223344 00000000 0
W 00100004 f deadbeef 00000000 0
R 00100000 f 00000000 11223344 0
W 00100000 3 0000aabb 00000000 0
W 00100000 8 99000000 00000000 0
R 00100000 f 00000000 9922aabb 0
W 00100004 6 00555500 00000000 0
R 00100004 f 00000000 de5555ef 0
W 00100ffc f cafef00d 00000000 0
R 00100ffc f 00000000 cafef00d 0
R 40000000 f 00000000 00000000 1
W 90000010 f 12345678 00000000 1
R 00110000 f 00000000 00000000 1
W 80000000 f a5c3e17b 00000000 0
O c3e17b
R 80000000 f 00000000 00c3e17b 0
W 80000000 2 00005500 00000000 0
O c3557b
R 80000000 f 00000000 00c3557b 0
G 1abc
R 80000004 f 00000000 00001abc 0
W 80040008 f 00000000 00000000 0
W 8004000c f 00000000 00000000 0
W 80040010 1 00000001 00000000 0
I 1
M
R 80040010 f 00000000 00000001 0
W 80040010 1 00000000 00000000 0
I 0

//--- list.f
source/periph_pkg.sv
source/bus_decoder.sv
source/sram_device.sv
source/gpio_device.sv
source/timer_device.sv
source/periph_top.sv
testbench/periph_asserts.sv
testbench/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_subsystem

sources:
  # RTL
  - files:
      - source/periph_pkg.sv
      - source/bus_decoder.sv
      - source/sram_device.sv
      - source/gpio_device.sv
      - source/timer_device.sv
      - source/periph_top.sv

  # Testbench
  - target: test
    files:
      - testbench/periph_asserts.sv
      - testbench/tb_periph_top.sv
